// ==== rtl/commit_check_pkg.sv ====
`default_nettype none

package commit_check_pkg;

  localparam int xlen = 64;

  // first pc at which core and reference are compared
  localparam logic [xlen-1:0] start_pc = 64'h0000_0000_8000_0000;

  // platform address map
  localparam logic [xlen-1:0] clint_base    = 64'h0000_00ff_f102_0000;
  localparam logic [xlen-1:0] mmr_mtime     = clint_base + 64'h0000_0000_0000_bff8;
  localparam logic [xlen-1:0] bootrom_start = 64'h0000_00ff_f101_0000;
  localparam logic [xlen-1:0] bootrom_end   = 64'h0000_00ff_f102_0000;
  localparam logic [xlen-1:0] uart_start    = 64'h0000_00ff_f0c2_c000;
  localparam logic [xlen-1:0] uart_end      = 64'h0000_00ff_f0d0_0000;

  // counter ranges and mip
  localparam logic [11:0] csr_mcycle          = 12'hb00;
  localparam logic [11:0] csr_mhpm_counter_31 = 12'hb1f;
  localparam logic [11:0] csr_cycle           = 12'hc00;
  localparam logic [11:0] csr_hpm_counter_31  = 12'hc1f;
  localparam logic [11:0] csr_mip             = 12'h344;

  localparam logic [6:0] op_load   = 7'h03;
  localparam logic [6:0] op_system = 7'h73;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic [4:0]      rd;
    logic            wr_en;
    logic [xlen-1:0] data;
    logic            excep;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] mem_addr;
  } commit_rec_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic            xcpt;
    logic [xlen-1:0] cause;
  } ref_rec_t;

  typedef struct packed {
    logic compressed;
    logic counter_read;
    logic mip_read;
    logic mtime_read;
    logic mmio_read;
    logic system;
  } instr_class_t;

  typedef struct packed {
    logic checked;
    logic exc;
    logic cause;
    logic both_exc;
    logic pc;
    logic instr;
    logic rd;
    logic data;
  } field_diff_t;

  // listed in reporting priority after err_none
  typedef enum logic [2:0] {
    err_none,
    err_exc,
    err_cause,
    err_pc,
    err_instr,
    err_rd,
    err_data,
    err_csr_data
  } err_code_t;

endpackage

`default_nettype wire

// ==== rtl/instr_classifier.sv ====
`default_nettype none

module instr_classifier
  import commit_check_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         commit_valid,
  input  commit_rec_t  core,
  output instr_class_t cls,
  output logic         cls_valid
);

  logic         wr_valid;
  logic         is_load;
  logic         is_system;
  logic [11:0]  csr_addr;
  logic         csr_in_counters;
  logic         addr_in_mmio;
  instr_class_t cls_d;

  // only a real register write can carry a value worth masking
  assign wr_valid  = core.wr_en && (core.rd != 5'd0);
  assign is_load   = core.instr[6:0] == op_load;
  assign is_system = core.instr[6:0] == op_system;
  assign csr_addr  = core.instr[31:20];

  assign csr_in_counters =
    ((csr_addr >= csr_mcycle) && (csr_addr <= csr_mhpm_counter_31)) ||
    ((csr_addr >= csr_cycle) && (csr_addr <= csr_hpm_counter_31));

  // boot rom and uart windows, end addresses inclusive
  assign addr_in_mmio =
    ((core.mem_addr >= bootrom_start) && (core.mem_addr <= bootrom_end)) ||
    ((core.mem_addr >= uart_start) && (core.mem_addr <= uart_end));

  always_comb begin
    cls_d              = '0;
    cls_d.compressed   = ~&core.instr[1:0];
    cls_d.system       = is_system;
    cls_d.counter_read = wr_valid && is_system && csr_in_counters;
    cls_d.mip_read     = wr_valid && is_system && (csr_addr == csr_mip);
    cls_d.mtime_read   = wr_valid && is_load && (core.mem_addr == mmr_mtime);
    cls_d.mmio_read    = wr_valid && is_load && addr_in_mmio;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cls_valid <= 1'b0;
    end else begin
      cls_valid <= commit_valid;
    end
  end

  // class bits only change on a commit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cls <= '0;
    end else if (commit_valid) begin
      cls <= cls_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/trace_comparator.sv ====
`default_nettype none

module trace_comparator
  import commit_check_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            commit_valid,
  input  commit_rec_t     core,
  input  ref_rec_t        golden,
  output field_diff_t     diff,
  output logic [4:0]      rd_q,
  output logic [xlen-1:0] data_q
);

  logic        armed;
  logic        at_start;
  logic        compressed;
  logic        wr_valid;
  field_diff_t diff_d;

  assign at_start   = core.pc == start_pc;
  assign compressed = ~&core.instr[1:0];
  assign wr_valid   = core.wr_en && (core.rd != 5'd0);

  always_comb begin
    diff_d          = '0;
    // the commit at start_pc is itself checked
    diff_d.checked  = commit_valid && (armed || at_start);
    diff_d.exc      = core.excep != golden.xcpt;
    diff_d.both_exc = core.excep && golden.xcpt;
    diff_d.cause    = diff_d.both_exc && (core.cause != golden.cause);
    diff_d.pc       = core.pc != golden.pc;
    if (compressed) begin
      diff_d.instr = core.instr[15:0] != golden.instr[15:0];
    end else begin
      diff_d.instr = core.instr != golden.instr;
    end
    // writes to x0 or without enable say nothing about rd
    diff_d.rd   = wr_valid && (core.rd != golden.rd);
    diff_d.data = wr_valid && (core.data != golden.data);
  end

  // armed once, cleared only by reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed <= 1'b0;
    end else if (commit_valid && at_start) begin
      armed <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      diff <= '0;
    end else if (commit_valid) begin
      diff <= diff_d;
    end else begin
      diff.checked <= 1'b0;
    end
  end

  // core value kept for a possible override
  always_ff @(posedge clk) begin
    if (commit_valid) begin
      rd_q   <= core.rd;
      data_q <= core.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mismatch_arbiter.sv ====
`default_nettype none

module mismatch_arbiter
  import commit_check_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            cls_valid,
  input  instr_class_t    cls,
  input  field_diff_t     diff,
  input  logic [4:0]      rd_q,
  input  logic [xlen-1:0] data_q,
  output logic            check_valid,
  output err_code_t       err_code,
  output logic            override_valid,
  output logic [4:0]      override_rd,
  output logic [xlen-1:0] override_data,
  output logic [15:0]     error_count
);

  logic      check_now;
  logic      override_cls;
  err_code_t code_d;

  assign check_now    = cls_valid && diff.checked;
  assign override_cls = cls.counter_read || cls.mip_read || cls.mtime_read || cls.mmio_read;

  // fixed priority, later fields only matter when exceptions agree to be absent
  always_comb begin
    code_d = err_none;
    if (diff.exc) begin
      code_d = err_exc;
    end else if (diff.cause) begin
      code_d = err_cause;
    end else if (!diff.both_exc) begin
      if (diff.pc) begin
        code_d = err_pc;
      end else if (diff.instr) begin
        code_d = err_instr;
      end else if (diff.rd) begin
        code_d = err_rd;
      end else if (diff.data && !override_cls) begin
        code_d = cls.system ? err_csr_data : err_data;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      check_valid    <= 1'b0;
      err_code       <= err_none;
      override_valid <= 1'b0;
      error_count    <= 16'd0;
    end else begin
      check_valid    <= check_now;
      err_code       <= check_now ? code_d : err_none;
      override_valid <= check_now && override_cls;
      // saturates at all ones
      if (check_now && (code_d != err_none) && !(&error_count)) begin
        error_count <= error_count + 16'd1;
      end
    end
  end

  // value the reference model takes over from the core
  always_ff @(posedge clk) begin
    if (check_now && override_cls) begin
      override_rd   <= rd_q;
      override_data <= data_q;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/commit_check_top.sv ====
`default_nettype none

module commit_check_top
  import commit_check_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            commit_valid,
  input  commit_rec_t     core,
  input  ref_rec_t        golden,
  output logic            check_valid,
  output err_code_t       err_code,
  output logic            override_valid,
  output logic [4:0]      override_rd,
  output logic [xlen-1:0] override_data,
  output logic [15:0]     error_count
);

  instr_class_t    cls;
  logic            cls_valid;
  field_diff_t     diff;
  logic [4:0]      rd_q;
  logic [xlen-1:0] data_q;

  // first stage, decode and compare side by side
  instr_classifier u_classifier (
    .clk          (clk),
    .arst_n       (arst_n),
    .commit_valid (commit_valid),
    .core         (core),
    .cls          (cls),
    .cls_valid    (cls_valid)
  );

  trace_comparator u_comparator (
    .clk          (clk),
    .arst_n       (arst_n),
    .commit_valid (commit_valid),
    .core         (core),
    .golden       (golden),
    .diff         (diff),
    .rd_q         (rd_q),
    .data_q       (data_q)
  );

  // second stage
  mismatch_arbiter u_arbiter (
    .clk            (clk),
    .arst_n         (arst_n),
    .cls_valid      (cls_valid),
    .cls            (cls),
    .diff           (diff),
    .rd_q           (rd_q),
    .data_q         (data_q),
    .check_valid    (check_valid),
    .err_code       (err_code),
    .override_valid (override_valid),
    .override_rd    (override_rd),
    .override_data  (override_data),
    .error_count    (error_count)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held over two rising edges, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/commit_check_tb.sv ====
`default_nettype none

module commit_check_tb
  import commit_check_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    commit_rec_t core;
    ref_rec_t    golden;
    err_code_t   exp_code;
    logic        exp_ovr;
    logic        exp_check;
  } row_t;

  logic            clk;
  logic            arst_n;
  logic            commit_valid;
  commit_rec_t     core;
  ref_rec_t        golden;
  logic            check_valid;
  err_code_t       err_code;
  logic            override_valid;
  logic [4:0]      override_rd;
  logic [xlen-1:0] override_data;
  logic [15:0]     error_count;

  row_t        rows[$];
  string       names[$];
  int          pend[$];
  commit_rec_t c_cur;
  ref_rec_t    g_cur;
  logic [63:0] row_pc;
  logic [31:0] lfsr_state;
  int          timeout_cycles = 12;
  int          checks;
  int          mismatches;
  int          failures;
  int          exp_errors;

  tb_clock_gen u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  commit_check_top dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .commit_valid   (commit_valid),
    .core           (core),
    .golden         (golden),
    .check_valid    (check_valid),
    .err_code       (err_code),
    .override_valid (override_valid),
    .override_rd    (override_rd),
    .override_data  (override_data),
    .error_count    (error_count)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic random_word(output logic [63:0] w);
    for (int b = 0; b < 64; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b]       = lfsr_state[0];
    end
  endtask

  // matching core and reference records at the next pc
  task automatic new_row(input logic [31:0] instr, input logic [63:0] addr);
    logic [63:0] d;
    random_word(d);
    c_cur          = '0;
    c_cur.pc       = row_pc;
    c_cur.instr    = instr;
    c_cur.rd       = instr[11:7];
    c_cur.wr_en    = 1'b1;
    c_cur.data     = d;
    c_cur.mem_addr = addr;
    g_cur.pc       = row_pc;
    g_cur.instr    = instr;
    g_cur.rd       = instr[11:7];
    g_cur.data     = d;
    g_cur.xcpt     = 1'b0;
    g_cur.cause    = '0;
    row_pc         = row_pc + 64'd4;
  endtask

  task automatic add_row(input string name, input err_code_t code, input logic ovr,
                         input logic chk);
    row_t r;
    r.core      = c_cur;
    r.golden    = g_cur;
    r.exp_code  = code;
    r.exp_ovr   = ovr;
    r.exp_check = chk;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    row_pc = 64'h1000;
    // a wrong pc before the start pc goes unchecked
    new_row(32'h00a28293, '0);
    g_cur.pc = g_cur.pc ^ 64'h10;
    add_row("boot_pc_diff", err_none, 1'b0, 1'b0);
    new_row(32'h00a28293, '0);
    add_row("boot_match", err_none, 1'b0, 1'b0);
    row_pc = start_pc;
    new_row(32'h00a28293, '0);
    add_row("start", err_none, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    g_cur.pc = g_cur.pc ^ 64'h10;
    add_row("pc_diff", err_pc, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    g_cur.instr = g_cur.instr ^ 32'h0010_0000;
    add_row("instr_diff", err_instr, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    g_cur.rd = 5'd6;
    add_row("rd_diff", err_rd, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    g_cur.data = ~g_cur.data;
    add_row("data_diff", err_data, 1'b0, 1'b1);
    // addi x0 writes nothing
    new_row(32'h00a00013, '0);
    g_cur.data = ~g_cur.data;
    add_row("x0_write", err_none, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    g_cur.pc    = g_cur.pc ^ 64'h10;
    g_cur.instr = g_cur.instr ^ 32'h0010_0000;
    g_cur.data  = ~g_cur.data;
    add_row("multi_diff", err_pc, 1'b0, 1'b1);
    // c.addi x8 with junk in the unused upper half of the word
    new_row(32'hdead_0405, '0);
    g_cur.instr = 32'h0000_0405;
    add_row("rvc_upper", err_none, 1'b0, 1'b1);
    new_row(32'h0000_0405, '0);
    g_cur.instr = 32'h0000_0409;
    add_row("rvc_lower", err_instr, 1'b0, 1'b1);
    // csr reads of mcycle, cycle, mip and mstatus
    new_row(32'hb0002373, '0);
    g_cur.data = ~g_cur.data;
    add_row("mcycle_read", err_none, 1'b1, 1'b1);
    new_row(32'hc00023f3, '0);
    g_cur.data = ~g_cur.data;
    add_row("cycle_read", err_none, 1'b1, 1'b1);
    new_row(32'h34402473, '0);
    g_cur.data = ~g_cur.data;
    add_row("mip_read", err_none, 1'b1, 1'b1);
    new_row(32'h300024f3, '0);
    g_cur.data = ~g_cur.data;
    add_row("mstatus_read", err_csr_data, 1'b0, 1'b1);
    // ld x10 from the platform map
    new_row(32'h0005b503, mmr_mtime);
    g_cur.data = ~g_cur.data;
    add_row("mtime_load", err_none, 1'b1, 1'b1);
    new_row(32'h0005b503, bootrom_start + 64'h40);
    g_cur.data = ~g_cur.data;
    add_row("bootrom_load", err_none, 1'b1, 1'b1);
    new_row(32'h0005b503, uart_start + 64'h8);
    g_cur.data = ~g_cur.data;
    add_row("uart_load", err_none, 1'b1, 1'b1);
    new_row(32'h0005b503, 64'h8000_2000);
    g_cur.data = ~g_cur.data;
    add_row("ram_load", err_data, 1'b0, 1'b1);
    // traps
    new_row(32'h00a28293, '0);
    c_cur.excep = 1'b1;
    c_cur.cause = 64'd2;
    add_row("exc_core_only", err_exc, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    c_cur.excep = 1'b1;
    c_cur.cause = 64'd2;
    g_cur.xcpt  = 1'b1;
    g_cur.cause = 64'd5;
    add_row("cause_diff", err_cause, 1'b0, 1'b1);
    new_row(32'h00a28293, '0);
    c_cur.excep = 1'b1;
    c_cur.cause = 64'd2;
    g_cur.xcpt  = 1'b1;
    g_cur.cause = 64'd2;
    g_cur.pc    = g_cur.pc ^ 64'h4;
    add_row("exc_pc_diff", err_none, 1'b0, 1'b1);
  endtask

  task automatic check_result(input int idx);
    row_t      r;
    err_code_t exp_c;
    r     = rows[idx];
    exp_c = r.exp_code;
    checks++;
    assert (err_code == exp_c) else begin
      $display("MISMATCH %s err_code expected %s actual %s", names[idx], exp_c.name(),
               err_code.name());
      mismatches++;
    end
    assert (override_valid == r.exp_ovr) else begin
      $display("MISMATCH %s override_valid expected %0b actual %0b", names[idx], r.exp_ovr,
               override_valid);
      mismatches++;
    end
    if (r.exp_ovr) begin
      assert (override_rd == r.core.rd && override_data == r.core.data) else begin
        $display("MISMATCH %s override expected x%0d=%h actual x%0d=%h", names[idx],
                 r.core.rd, r.core.data, override_rd, override_data);
        mismatches++;
      end
    end
  endtask

  task automatic drive_row(input int idx);
    row_t r;
    r            = rows[idx];
    commit_valid = 1'b1;
    core         = r.core;
    golden       = r.golden;
    if (r.exp_check && r.exp_code != err_none) begin
      exp_errors++;
    end
  endtask

  task automatic run_single(input int idx);
    row_t r;
    int   cycles;
    r = rows[idx];
    @(negedge clk);
    drive_row(idx);
    @(negedge clk);
    commit_valid = 1'b0;
    if (r.exp_check) begin
      cycles = 0;
      while (!check_valid && cycles < timeout_cycles) begin
        @(negedge clk);
        cycles++;
      end
      assert (check_valid) else begin
        $display("timed out waiting for check_valid on row %s", names[idx]);
        failures++;
      end
      if (check_valid) begin
        // the result belongs in the cycle after the second edge
        assert (cycles == 1) else begin
          $display("row %s gave check_valid in the wrong cycle", names[idx]);
          failures++;
        end
        check_result(idx);
      end
    end else begin
      // two-edge slot in which no result may appear
      repeat (2) begin
        assert (!check_valid && !override_valid) else begin
          $display("row %s gave a result before the start pc was reached", names[idx]);
          failures++;
        end
        @(negedge clk);
      end
    end
  endtask

  // matches a result against the oldest commit in flight
  task automatic collect();
    if (check_valid) begin
      assert (pend.size() > 0) else begin
        $display("check_valid seen with no commit in flight");
        failures++;
      end
      if (pend.size() > 0) begin
        check_result(pend.pop_front());
      end
    end
  endtask

  task automatic run_burst();
    int cycles;
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].exp_check) begin
        @(negedge clk);
        collect();
        drive_row(i);
        pend.push_back(i);
      end
    end
    @(negedge clk);
    collect();
    commit_valid = 1'b0;
    cycles = 0;
    while (pend.size() > 0 && cycles < timeout_cycles) begin
      @(negedge clk);
      collect();
      cycles++;
    end
    assert (pend.size() == 0) else begin
      $display("burst timed out with %0d results missing", pend.size());
      failures++;
    end
  endtask

  initial begin
    int cycles;
    commit_valid = 1'b0;
    core         = '0;
    golden       = '0;
    lfsr_state   = 32'h5b8f;
    checks       = 0;
    mismatches   = 0;
    failures     = 0;
    exp_errors   = 0;
    build_table();

    cycles = 0;
    while (arst_n !== 1'b1 && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    assert (arst_n === 1'b1) else begin
      $display("reset was never released");
      failures++;
    end
    assert (!check_valid && !override_valid && error_count == 16'd0 && err_code == err_none)
    else begin
      $display("outputs are not at their reset values");
      failures++;
    end

    for (int i = 0; i < rows.size(); i++) begin
      run_single(i);
    end
    // every armed row again at one commit per cycle
    run_burst();

    @(negedge clk);
    assert (error_count == exp_errors) else begin
      $display("MISMATCH error_count expected %0d actual %0d", exp_errors, error_count);
      mismatches++;
    end

    $display("results checked %0d, mismatches %0d, other errors %0d", checks, mismatches,
             failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== commit_check.f ====
rtl/commit_check_pkg.sv
rtl/instr_classifier.sv
rtl/trace_comparator.sv
rtl/mismatch_arbiter.sv
rtl/commit_check_top.sv
verification/tb_clock_gen.sv
verification/commit_check_tb.sv
